/* rtl/elink_pkg.sv */
package elink_pkg;

   //##############################
   // Fabric packet fields
   //##############################
   localparam int PW         = 104;   // Full packet width
   localparam int WRITE_W    = 1;
   localparam int DATAMODE_W = 2;
   localparam int CTRLMODE_W = 5;
   localparam int DSTADDR_W  = 32;
   localparam int DATA_W     = 32;
   localparam int SRCADDR_W  = 32;

   // Field positions, LSB first
   localparam int WRITE_LSB    = 0;
   localparam int DATAMODE_LSB = WRITE_LSB + WRITE_W;        // 1
   localparam int CTRLMODE_LSB = DATAMODE_LSB + DATAMODE_W;  // 3
   localparam int DSTADDR_LSB  = CTRLMODE_LSB + CTRLMODE_W;  // 8
   localparam int DATA_LSB     = DSTADDR_LSB + DSTADDR_W;    // 40
   localparam int SRCADDR_LSB  = DATA_LSB + DATA_W;          // 72

   // Bytes carried by one slow beat
   localparam int BYTES_PER_BEAT = 8;

   // Transfer size of the access
   typedef enum logic [DATAMODE_W-1:0] {
      DM_BYTE   = 2'd0,
      DM_HALF   = 2'd1,
      DM_WORD   = 2'd2,
      DM_DOUBLE = 2'd3
   } emesh_datamode_t;

   //##############################
   // Wire frame patterns
   //##############################
   // MSB goes out in the first fast cycle of the beat
   // Head starts low so the receiver sees a rising frame
   typedef enum logic [3:0] {
      FRAME_IDLE = 4'b0000,
      FRAME_HEAD = 4'b0111,   // Packet start marker
      FRAME_BODY = 4'b1111
   } frame_code_t;

endpackage

/* rtl/etx_io_pkg.sv */
package etx_io_pkg;

   //##############################
   // Board variants
   //##############################
   // Decides how the write-wait pin is received
   typedef enum logic {
      ETYPE_PARALLELLA = 1'b0,   // Differential write wait
      ETYPE_EPHYCARD   = 1'b1    // Single ended write wait
   } etx_type_t;

   //##############################
   // Pin and beat geometry
   //##############################
   localparam int LANES = 8;           // DDR data lanes

   // One slow beat as handed over from the protocol
   localparam int SLOW_W = 64;

   // Frame bits per beat, one per fast cycle
   localparam int FRAME_W = 4;

   // Fast clock cycles in one slow cycle
   localparam int FAST_PER_SLOW = 4;

endpackage

/* rtl/oh_edgealign.sv */
`timescale 1ns/1ps

// Marks the fast cycle that ends on the slow rising edge
// Slow clock is 1/4 of the fast clock, both rising together
//
//   fast negedge samples   1   1   0   0 | 1   1   0   0
//   firstedge              0   0   0   1 | 0   0   0   1
//
// Two low samples in a row means the next fast posedge is aligned
module oh_edgealign (
   input  logic tx_lclk_io,     // Fast clock
   input  logic tx_lclk_div4,   // Slow clock
   output logic firstedge       // High in the fast cycle before the slow edge
);

   logic [1:0] slow_hist;       // Slow clock level seen on fast falling edges

   // Sample away from the fast rising edge so the slow level is settled
   always_ff @(negedge tx_lclk_io)
   begin
      slow_hist[0] <= tx_lclk_div4;
      slow_hist[1] <= slow_hist[0];   // Older sample
   end

   // Second low sample of the slow period
   // Stays valid across the following fast posedge
   assign firstedge = ~slow_hist[0] & ~slow_hist[1];

endmodule

/* rtl/transmit_protocol.sv */
`timescale 1ns/1ps

// Turns one fabric packet into a head beat and a body beat
module transmit_protocol
   import elink_pkg::*;
   import etx_io_pkg::*;
(
   input  logic                 tx_lclk_div4,
   input  logic                 rst,
   // Fabric side
   input  logic                 tx_access,      // Packet offered
   input  logic [PW-1:0]        tx_packet,
   output logic                 tx_wait,        // Hold the offered packet
   // IO side
   output logic [SLOW_W-1:0]    tx_data_slow,
   output logic [FRAME_W-1:0]   tx_frame_slow,
   input  logic                 tx_wr_wait,     // Synchronized pushback
   input  logic                 tx_rd_wait
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_HEAD,   // Beat 0 on the outputs
      ST_BODY    // Beat 1 on the outputs
   } tx_state_t;

   tx_state_t state;
   tx_state_t state_nxt;

   logic                  offer_write;   // Write flag of the offered packet
   logic                  blocked;       // Pushback hits the offered packet
   logic                  accept;
   logic [PW-1:0]         pkt_q;         // Packet being sent

   // Fields of the registered packet
   logic                  pkt_write;
   emesh_datamode_t       pkt_datamode;
   logic [CTRLMODE_W-1:0] pkt_ctrlmode;
   logic [DSTADDR_W-1:0]  pkt_dstaddr;
   logic [DATA_W-1:0]     pkt_data;
   logic [SRCADDR_W-1:0]  pkt_srcaddr;

   logic [7:0]            head_bytes [BYTES_PER_BEAT];
   logic [7:0]            body_bytes [BYTES_PER_BEAT];

   // Wire byte k into the beat word
   // Each 16 bit fast word sends its upper byte first, so even bytes sit high
   // Position works out to 8*(k^1)
   function automatic logic [SLOW_W-1:0] pack_beat(input logic [7:0] b [BYTES_PER_BEAT]);
      logic [SLOW_W-1:0] w;
      w = '0;
      for (int k = 0; k < BYTES_PER_BEAT; k++)
      begin
         w[8*(k^1) +: 8] = b[k];
      end
      return w;
   endfunction

   //##############################
   // Accept and stall
   //##############################
   assign offer_write = tx_packet[WRITE_LSB];
   assign blocked     = tx_access & (offer_write ? tx_wr_wait : tx_rd_wait);

   // No new packet while the head beat is going out
   assign tx_wait = (state == ST_HEAD) | blocked;
   assign accept  = tx_access & ~tx_wait;

   always_comb
   begin
      if (accept)
         state_nxt = ST_HEAD;               // Also back to back after body
      else if (state == ST_HEAD)
         state_nxt = ST_BODY;               // Body always follows the head
      else
         state_nxt = ST_IDLE;
   end

   always_ff @(posedge tx_lclk_div4)
   begin
      if (rst)
         state <= ST_IDLE;
      else
         state <= state_nxt;
   end

   // Payload capture
   always_ff @(posedge tx_lclk_div4)
   begin
      if (accept)
         pkt_q <= tx_packet;
   end

   //##############################
   // Beat assembly
   //##############################
   assign pkt_write    = pkt_q[WRITE_LSB];
   assign pkt_datamode = emesh_datamode_t'(pkt_q[DATAMODE_LSB +: DATAMODE_W]);
   assign pkt_ctrlmode = pkt_q[CTRLMODE_LSB +: CTRLMODE_W];
   assign pkt_dstaddr  = pkt_q[DSTADDR_LSB +: DSTADDR_W];
   assign pkt_data     = pkt_q[DATA_LSB +: DATA_W];
   assign pkt_srcaddr  = pkt_q[SRCADDR_LSB +: SRCADDR_W];

   always_comb
   begin
      head_bytes[0] = 8'h00;                                     // Pad
      head_bytes[1] = {pkt_ctrlmode, pkt_datamode, pkt_write};
      head_bytes[2] = pkt_dstaddr[31:24];                        // MSB first
      head_bytes[3] = pkt_dstaddr[23:16];
      head_bytes[4] = pkt_dstaddr[15:8];
      head_bytes[5] = pkt_dstaddr[7:0];
      head_bytes[6] = pkt_data[31:24];                           // Upper data half
      head_bytes[7] = pkt_data[23:16];

      body_bytes[0] = pkt_data[15:8];                            // Lower data half
      body_bytes[1] = pkt_data[7:0];
      body_bytes[2] = pkt_srcaddr[31:24];
      body_bytes[3] = pkt_srcaddr[23:16];
      body_bytes[4] = pkt_srcaddr[15:8];
      body_bytes[5] = pkt_srcaddr[7:0];
      body_bytes[6] = 8'h00;
      body_bytes[7] = 8'h00;
   end

   // Outputs decoded from registered state, so they change on the slow edge
   always_comb
   begin
      case (state)
         ST_HEAD:
         begin
            tx_data_slow  = pack_beat(head_bytes);
            tx_frame_slow = FRAME_HEAD;
         end
         ST_BODY:
         begin
            tx_data_slow  = pack_beat(body_bytes);
            tx_frame_slow = FRAME_BODY;
         end
         default:
         begin
            tx_data_slow  = '0;             // Quiet lanes when idle
            tx_frame_slow = FRAME_IDLE;
         end
      endcase
   end

endmodule

/* rtl/etx_io.sv */
`timescale 1ns/1ps

// Slow beat to DDR pins, plus pushback pins back to the slow side
module etx_io
   import etx_io_pkg::*;
#(
   parameter etx_type_t ETYPE       = ETYPE_PARALLELLA,
   parameter logic      INVERT_PINS = 1'b0          // Board swaps p and n
)
(
   // Clocks
   input  logic               tx_lclk_io,       // Fast DDR clock
   input  logic               tx_lclk_div4,     // Slow clock
   input  logic               tx_lclk90,        // Fast clock shifted 90 degrees
   // From the protocol
   input  logic [SLOW_W-1:0]  tx_data_slow,
   input  logic [FRAME_W-1:0] tx_frame_slow,
   // Link pins
   output logic               txo_lclk_p,
   output logic               txo_lclk_n,
   output logic               txo_frame_p,
   output logic               txo_frame_n,
   output logic [LANES-1:0]   txo_data_p,
   output logic [LANES-1:0]   txo_data_n,
   input  logic               txi_wr_wait_p,
   input  logic               txi_wr_wait_n,
   input  logic               txi_rd_wait_p,
   input  logic               txi_rd_wait_n,
   // Back to the protocol
   output logic               tx_wr_wait,
   output logic               tx_rd_wait
);

   localparam int FAST_W = SLOW_W / FAST_PER_SLOW;   // 16 bits per fast cycle

   logic               firstedge;
   logic [SLOW_W-1:0]  tx_data;        // Fast shift register
   logic [FRAME_W-1:0] tx_frame;

   logic [LANES:0]     ddr_d1;         // Frame on the top bit
   logic [LANES:0]     ddr_d2;
   logic [LANES:0]     ddr_rise;
   logic [LANES:0]     ddr_fall_pre;
   logic [LANES:0]     ddr_fall;
   logic [LANES:0]     ddr_q;

   logic               lclk_rise;
   logic               lclk_fall_pre;
   logic               lclk_fall;
   logic               lclk_q;

   logic               wr_wait_async;
   logic               rd_wait_async;
   logic               wr_wait_sync;
   logic               rd_wait_sync;
   logic               wr_wait_reg;
   logic               wr_wait_reg2;
   logic               rd_wait_reg;
   logic               rd_wait_reg2;

   //##############################
   // Slow to fast serializer
   //##############################
   oh_edgealign edgealign0 (
      .tx_lclk_io   (tx_lclk_io),
      .tx_lclk_div4 (tx_lclk_div4),
      .firstedge    (firstedge)
   );

   always_ff @(posedge tx_lclk_io)
   begin
      if (firstedge)
      begin
         tx_data  <= tx_data_slow;                          // New beat
         tx_frame <= tx_frame_slow;
      end
      else
      begin
         tx_data  <= {{FAST_W{1'b0}}, tx_data[SLOW_W-1:FAST_W]};   // Next 16 bits down
         tx_frame <= {tx_frame[FRAME_W-2:0], 1'b0};                 // Frame MSB first
      end
   end

   // Upper byte on the rising half, lower on the falling half
   // Frame holds for the whole fast cycle
   assign ddr_d1 = {tx_frame[FRAME_W-1], tx_data[2*LANES-1:LANES]} ^ {(LANES+1){INVERT_PINS}};
   assign ddr_d2 = {tx_frame[FRAME_W-1], tx_data[LANES-1:0]} ^ {(LANES+1){INVERT_PINS}};

   //##############################
   // DDR output pairs
   //##############################
   // Both halves captured on the rising edge
   always_ff @(posedge tx_lclk_io)
   begin
      ddr_rise     <= ddr_d1;
      ddr_fall_pre <= ddr_d2;
   end

   always_ff @(negedge tx_lclk_io)
   begin
      ddr_fall <= ddr_fall_pre;        // Second half waits for the falling edge
   end

   assign ddr_q = tx_lclk_io ? ddr_rise : ddr_fall;

   // Forwarded clock, high then low each cycle of the shifted clock
   always_ff @(posedge tx_lclk90)
   begin
      lclk_rise     <= 1'b1 ^ INVERT_PINS;
      lclk_fall_pre <= 1'b0 ^ INVERT_PINS;
   end

   always_ff @(negedge tx_lclk90)
   begin
      lclk_fall <= lclk_fall_pre;
   end

   assign lclk_q = tx_lclk90 ? lclk_rise : lclk_fall;

   // True and complement pins
   assign txo_data_p  = ddr_q[LANES-1:0];
   assign txo_data_n  = ~ddr_q[LANES-1:0];
   assign txo_frame_p = ddr_q[LANES];
   assign txo_frame_n = ~ddr_q[LANES];
   assign txo_lclk_p  = lclk_q;
   assign txo_lclk_n  = ~lclk_q;

   //##############################
   // Pushback receive and sync
   //##############################
   generate
      if (ETYPE == ETYPE_PARALLELLA)
      begin : g_wr_diff
         assign wr_wait_async = txi_wr_wait_p & ~txi_wr_wait_n;   // Differential receive
      end
      else
      begin : g_wr_se
         assign wr_wait_async = txi_wr_wait_p;
      end
   endgenerate

   assign rd_wait_async = txi_rd_wait_p;     // Single ended on every board

   // First stage on the fast falling edge
   always_ff @(negedge tx_lclk_io)
   begin
      wr_wait_sync <= wr_wait_async ^ INVERT_PINS;
      rd_wait_sync <= rd_wait_async ^ INVERT_PINS;
   end

   always_ff @(posedge tx_lclk_div4)
   begin
      wr_wait_reg  <= wr_wait_sync;
      wr_wait_reg2 <= wr_wait_reg;
      rd_wait_reg  <= rd_wait_sync;
      rd_wait_reg2 <= rd_wait_reg;
   end

   // Stretch so one short pulse holds for two slow cycles
   assign tx_wr_wait = wr_wait_reg | wr_wait_reg2;
   assign tx_rd_wait = rd_wait_reg | rd_wait_reg2;

endmodule

/* rtl/etx.sv */
`timescale 1ns/1ps

// Link transmitter top
module etx
   import elink_pkg::*;
   import etx_io_pkg::*;
#(
   parameter etx_type_t ETYPE       = ETYPE_PARALLELLA,
   parameter logic      INVERT_PINS = 1'b0
)
(
   // Clocks and reset
   input  logic               tx_lclk_io,
   input  logic               tx_lclk_div4,
   input  logic               tx_lclk90,
   input  logic               rst,
   // Fabric side
   input  logic               tx_access,
   input  logic [PW-1:0]      tx_packet,
   output logic               tx_wait,
   // Link pins
   output logic               txo_lclk_p,
   output logic               txo_lclk_n,
   output logic               txo_frame_p,
   output logic               txo_frame_n,
   output logic [LANES-1:0]   txo_data_p,
   output logic [LANES-1:0]   txo_data_n,
   input  logic               txi_wr_wait_p,
   input  logic               txi_wr_wait_n,
   input  logic               txi_rd_wait_p,
   input  logic               txi_rd_wait_n
);

   logic [SLOW_W-1:0]  tx_data_slow;    // Beat word
   logic [FRAME_W-1:0] tx_frame_slow;   // Beat frame pattern
   logic               tx_wr_wait;      // Pushback, slow domain
   logic               tx_rd_wait;

   transmit_protocol protocol0 (
      .tx_lclk_div4  (tx_lclk_div4),
      .rst           (rst),
      .tx_access     (tx_access),
      .tx_packet     (tx_packet),
      .tx_wait       (tx_wait),
      .tx_data_slow  (tx_data_slow),
      .tx_frame_slow (tx_frame_slow),
      .tx_wr_wait    (tx_wr_wait),
      .tx_rd_wait    (tx_rd_wait)
   );

   etx_io #(
      .ETYPE       (ETYPE),
      .INVERT_PINS (INVERT_PINS)
   ) io0 (
      .tx_lclk_io    (tx_lclk_io),
      .tx_lclk_div4  (tx_lclk_div4),
      .tx_lclk90     (tx_lclk90),
      .tx_data_slow  (tx_data_slow),
      .tx_frame_slow (tx_frame_slow),
      .txo_lclk_p    (txo_lclk_p),
      .txo_lclk_n    (txo_lclk_n),
      .txo_frame_p   (txo_frame_p),
      .txo_frame_n   (txo_frame_n),
      .txo_data_p    (txo_data_p),
      .txo_data_n    (txo_data_n),
      .txi_wr_wait_p (txi_wr_wait_p),
      .txi_wr_wait_n (txi_wr_wait_n),
      .txi_rd_wait_p (txi_rd_wait_p),
      .txi_rd_wait_n (txi_rd_wait_n),
      .tx_wr_wait    (tx_wr_wait),
      .tx_rd_wait    (tx_rd_wait)
   );

endmodule

/* verif/elink_rx_model.sv */
`timescale 1ns/1ps

// Pin level receiver for the link, rebuilds fabric packets
module elink_rx_model
   import elink_pkg::*;
#(
   parameter logic INVERT_PINS = 1'b0
)
(
   input  logic          lclk_p,        // Forwarded clock pin
   input  logic          frame_p,
   input  logic [7:0]    data_p,
   output logic          pkt_valid,     // One lclk cycle per rebuilt packet
   output logic [PW-1:0] pkt_out
);

   localparam int PKT_BYTES = 2 * BYTES_PER_BEAT;

   logic       lclk;
   logic       frame;
   logic [7:0] data;
   logic [7:0] hi_byte;                 // Byte seen on the rising edge
   logic       frame_now;
   logic       frame_prev = 1'b1;       // No false start out of X
   logic [7:0] prev_hi;
   logic [7:0] prev_lo;
   logic [7:0] pkt_bytes [PKT_BYTES];
   int         nbytes = 0;
   logic       active = 1'b0;           // Collecting a packet

   // Undo board inversion
   assign lclk  = lclk_p ^ INVERT_PINS;
   assign frame = frame_p ^ INVERT_PINS;
   assign data  = data_p ^ {8{INVERT_PINS}};

   initial
   begin
      pkt_valid = 1'b0;
   end

   always @(posedge lclk)
   begin
      hi_byte   <= data;
      frame_now <= frame;               // Frame holds for the whole cycle
   end

   // One fast cycle complete on the falling edge
   always @(negedge lclk)
   begin : rx_cycle
      logic done;
      done = 1'b0;
      if (frame_prev === 1'b0 && frame_now === 1'b1)
      begin
         // Frame rose, previous cycle opened the head beat
         pkt_bytes[0] = prev_hi;
         pkt_bytes[1] = prev_lo;
         pkt_bytes[2] = hi_byte;
         pkt_bytes[3] = data;
         nbytes = 4;
         active = 1'b1;
      end
      else if (active)
      begin
         pkt_bytes[nbytes]   = hi_byte;
         pkt_bytes[nbytes+1] = data;
         nbytes += 2;
         if (nbytes == PKT_BYTES)
         begin
            done   = 1'b1;
            active = 1'b0;
         end
      end
      // Source, data, destination, then the control byte
      if (done)
         pkt_out <= {pkt_bytes[10], pkt_bytes[11], pkt_bytes[12], pkt_bytes[13],
                     pkt_bytes[6], pkt_bytes[7], pkt_bytes[8], pkt_bytes[9],
                     pkt_bytes[2], pkt_bytes[3], pkt_bytes[4], pkt_bytes[5],
                     pkt_bytes[1]};
      pkt_valid <= done;
      prev_hi    = hi_byte;
      prev_lo    = data;
      frame_prev = frame_now;
   end

endmodule

/* verif/etx_tb.sv */
`timescale 1ns/1ps

module etx_tb
   import elink_pkg::*;
   import etx_io_pkg::*;
();

   localparam etx_type_t ETYPE       = ETYPE_PARALLELLA;
   localparam logic      INVERT_PINS = 1'b1;      // Swapped pins on the board
   localparam int        LIMIT       = 40;        // Slow cycles per wait

   logic            tx_lclk_div4 = 1'b1;
   logic            tx_lclk_io   = 1'b1;
   logic            tx_lclk90    = 1'b1;
   logic            rst;
   logic            tx_access;
   logic [PW-1:0]   tx_packet;
   logic            tx_wait;
   logic            txo_lclk_p;
   logic            txo_lclk_n;
   logic            txo_frame_p;
   logic            txo_frame_n;
   logic [LANES-1:0] txo_data_p;
   logic [LANES-1:0] txo_data_n;
   logic            txi_wr_wait_p;
   logic            txi_wr_wait_n;
   logic            txi_rd_wait_p;
   logic            txi_rd_wait_n;

   logic            rx_valid;
   logic [PW-1:0]   rx_packet;
   logic            rx_lclk;
   logic [PW-1:0]   exp_q [$];                    // Scoreboard
   logic [PW-1:0]   got_q [$];
   int              accepted_wr  = 0;
   int              accepted_rd  = 0;
   int              frame_cycles = 0;
   int              lclk_edges   = 0;
   integer          seed = 32'he1eb;
   int              test_errors  = 0;
   int              total_tests  = 0;
   int              failed_tests = 0;
   int              total_errors = 0;

   // ##############################
   // Clocks and instances
   // ##############################
   always #50 tx_lclk_div4 = ~tx_lclk_div4;
   always #12.5 tx_lclk_io = ~tx_lclk_io;        // Rises with the slow clock
   always @(tx_lclk_io)
      tx_lclk90 <= #6.25 tx_lclk_io;            // Quarter fast period late

   etx #(.ETYPE(ETYPE), .INVERT_PINS(INVERT_PINS)) uut (.*);

   elink_rx_model #(.INVERT_PINS(INVERT_PINS)) rx0 (
      .lclk_p    (txo_lclk_p),
      .frame_p   (txo_frame_p),
      .data_p    (txo_data_p),
      .pkt_valid (rx_valid),
      .pkt_out   (rx_packet)
   );

   assign rx_lclk = txo_lclk_p ^ INVERT_PINS;

   // Acceptance seen at the fabric port
   always @(posedge tx_lclk_div4)
   begin
      if (rst === 1'b0 && tx_access && !tx_wait)
      begin
         exp_q.push_back(tx_packet);
         if (tx_packet[WRITE_LSB])
            accepted_wr++;
         else
            accepted_rd++;
      end
   end

   always @(posedge rx_lclk)
   begin
      lclk_edges++;
      if (rx_valid === 1'b1)
         got_q.push_back(rx_packet);             // Model output, valid set on negedge
   end

   // Mid cycle, data pins settled
   always @(posedge tx_lclk90)
   begin
      if ((txo_frame_p ^ INVERT_PINS) !== 1'b0)
         frame_cycles++;
      if (rst === 1'b0)
         require("link_pins",
                 (txo_data_n === ~txo_data_p) && (txo_frame_n === ~txo_frame_p),
                 "data or frame complement pin does not mirror its true pin");
   end

   // Forwarded clock is steady on the fast edges
   always @(posedge tx_lclk_io)
   begin
      if (rst === 1'b0)
         require("link_pins", txo_lclk_n === ~txo_lclk_p,
                 "lclk complement pin does not mirror lclk");
   end

   // ##############################
   // Helpers
   // ##############################
   task automatic compare_value(input string name, input logic [PW-1:0] exp,
                                input logic [PW-1:0] act);
      assert (act === exp)
      else
      begin
         $display("Fail %s expected %0h actual %0h", name, exp, act);
         test_errors++;
      end
   endtask

   task automatic require(input string name, input logic cond, input string what);
      assert (cond === 1'b1)
      else
      begin
         $display("%s: %s", name, what);
         test_errors++;
      end
   endtask

   function automatic logic [PW-1:0] random_packet();
      logic [127:0] r;
      r = {$random(seed), $random(seed), $random(seed), $random(seed)};
      return r[PW-1:0];
   endfunction

   // Pin levels as the link partner drives them
   task automatic set_wr_wait(input logic level);
      txi_wr_wait_p = level ^ INVERT_PINS;
      txi_wr_wait_n = ~(level ^ INVERT_PINS);
   endtask

   task automatic set_rd_wait(input logic level);
      txi_rd_wait_p = level ^ INVERT_PINS;
      txi_rd_wait_n = ~(level ^ INVERT_PINS);   // Unused by the receiver
   endtask

   // Offer one packet, hold it until taken
   task automatic send_packet(input string name, input logic [PW-1:0] pkt);
      int   n;
      logic taken;
      n = 0;
      taken = 1'b0;
      @(negedge tx_lclk_div4);
      tx_access = 1'b1;
      tx_packet = pkt;
      while (!taken && n < LIMIT)
      begin
         @(posedge tx_lclk_div4);
         taken = !tx_wait;
         n++;
      end
      @(negedge tx_lclk_div4);
      tx_access = 1'b0;
      require(name, taken, "packet was never accepted");
   endtask

   // Every accepted packet rebuilt, in order
   task automatic wait_deliveries(input string name);
      int            n;
      logic [PW-1:0] exp;
      logic [PW-1:0] got;
      n = 0;
      while (got_q.size() < exp_q.size() && n < LIMIT)
      begin
         @(negedge tx_lclk_div4);
         n++;
      end
      require(name, got_q.size() == exp_q.size(), "model did not rebuild every packet");
      while (exp_q.size() > 0 && got_q.size() > 0)
      begin
         exp = exp_q.pop_front();
         got = got_q.pop_front();
         compare_value(name, exp, got);
      end
      exp_q.delete();
      got_q.delete();
   endtask

   task automatic finish_test(input string name);
      total_tests++;
      total_errors += test_errors;
      if (test_errors == 0)
         $display("test %s: ok", name);
      else
      begin
         failed_tests++;
         $display("test %s: %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   // ##############################
   // Test sequence
   // ##############################
   initial
   begin : main
      int            base_lclk;
      int            base_frames;
      int            base_wr;
      int            base_rd;
      int            n;
      int            high;
      logic          taken;
      logic [PW-1:0] pkt;
      rst = 1'b1;
      tx_access = 1'b0;
      tx_packet = '0;
      set_wr_wait(1'b0);
      set_rd_wait(1'b0);
      repeat (2) @(posedge tx_lclk_div4);
      @(negedge tx_lclk_div4);
      rst = 1'b0;

      // Idle link after reset
      base_lclk   = lclk_edges;
      base_frames = frame_cycles;
      repeat (8)
      begin
         @(posedge tx_lclk_div4);
         require("reset_idle", !tx_wait, "tx_wait high after reset");
      end
      compare_value("reset_idle", 0, frame_cycles - base_frames);
      require("reset_idle", lclk_edges - base_lclk >= 30, "lclk is not toggling");
      finish_test("reset_idle");

      pkt = random_packet();
      pkt[WRITE_LSB] = 1'b1;
      send_packet("single_write", pkt);
      wait_deliveries("single_write");
      finish_test("single_write");

      for (int i = 0; i < 20; i++)
         send_packet("random_b2b", random_packet());     // Mixed reads and writes
      wait_deliveries("random_b2b");
      finish_test("random_b2b");

      // Write held off by write wait
      @(negedge tx_lclk_div4);
      set_wr_wait(1'b1);
      repeat (4) @(negedge tx_lclk_div4);             // Sync delay is 2 to 3 slow edges
      pkt = random_packet();
      pkt[WRITE_LSB] = 1'b1;
      base_wr     = accepted_wr;
      base_frames = frame_cycles;
      tx_access = 1'b1;
      tx_packet = pkt;
      repeat (8)
      begin
         @(posedge tx_lclk_div4);
         require("wr_wait_hold", tx_wait, "tx_wait low while write wait is held");
      end
      compare_value("wr_wait_hold", base_wr, accepted_wr);
      compare_value("wr_wait_hold", base_frames, frame_cycles);
      @(negedge tx_lclk_div4);
      set_wr_wait(1'b0);
      n = 0;
      while (accepted_wr == base_wr && n < LIMIT)
      begin
         @(negedge tx_lclk_div4);
         n++;
      end
      tx_access = 1'b0;
      require("wr_wait_hold", accepted_wr != base_wr, "held write never accepted");
      wait_deliveries("wr_wait_hold");
      finish_test("wr_wait_hold");

      // Read blocked, write still passes
      @(negedge tx_lclk_div4);
      set_rd_wait(1'b1);
      repeat (4) @(negedge tx_lclk_div4);
      base_rd = accepted_rd;
      pkt = random_packet();
      pkt[WRITE_LSB] = 1'b0;
      tx_access = 1'b1;
      tx_packet = pkt;
      repeat (4)
      begin
         @(posedge tx_lclk_div4);
         require("rd_wait_hold", tx_wait, "tx_wait low for a read under read wait");
      end
      pkt = random_packet();
      pkt[WRITE_LSB] = 1'b1;
      send_packet("rd_wait_hold", pkt);
      compare_value("rd_wait_hold", base_rd, accepted_rd);
      set_rd_wait(1'b0);
      wait_deliveries("rd_wait_hold");
      finish_test("rd_wait_hold");

      // One slow cycle pulse on read wait
      @(negedge tx_lclk_div4);
      set_rd_wait(1'b1);
      @(negedge tx_lclk_div4);
      set_rd_wait(1'b0);
      pkt = random_packet();
      pkt[WRITE_LSB] = 1'b0;
      tx_access = 1'b1;
      tx_packet = pkt;
      n = 0;
      high = 0;
      taken = 1'b0;
      while (!taken && n < LIMIT)
      begin
         @(posedge tx_lclk_div4);
         if (tx_wait)
            high++;
         else
            taken = 1'b1;
         n++;
      end
      @(negedge tx_lclk_div4);
      tx_access = 1'b0;
      require("wait_pulse", high >= 2, "tx_wait did not stay high for two slow cycles");
      require("wait_pulse", taken, "read never accepted after the pulse");
      wait_deliveries("wait_pulse");
      finish_test("wait_pulse");

      $display("tests %0d, failed %0d, errors %0d", total_tests, failed_tests, total_errors);
      if (total_errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

/* tb.f */
rtl/elink_pkg.sv
rtl/etx_io_pkg.sv
rtl/oh_edgealign.sv
rtl/transmit_protocol.sv
rtl/etx_io.sv
rtl/etx.sv
verif/elink_rx_model.sv
verif/etx_tb.sv
